// File: rtl/isa_pkg.sv
// instruction encoding for the core; imported by the RTL blocks and the testbench
`default_nettype none

package isa_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int REG_COUNT = 32;

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [5:0] opcode_t;
  typedef logic [4:0] sub_opcode_t;

  // major opcodes, bits 30..25
  localparam opcode_t OP_ALU = 6'b100000;
  localparam opcode_t OP_ADDI = 6'b101000;
  localparam opcode_t OP_ORI = 6'b101100;
  localparam opcode_t OP_XORI = 6'b101011;
  localparam opcode_t OP_MOVI = 6'b100010;

  // sub-opcodes of the alu group, bits 4..0
  localparam sub_opcode_t SUB_ADD = 5'b00000;
  localparam sub_opcode_t SUB_SUB = 5'b00001;
  localparam sub_opcode_t SUB_AND = 5'b00010;
  localparam sub_opcode_t SUB_XOR = 5'b00011;
  localparam sub_opcode_t SUB_OR = 5'b00100;
  localparam sub_opcode_t SUB_SLLI = 5'b01000;
  localparam sub_opcode_t SUB_SRLI = 5'b01001;
  localparam sub_opcode_t SUB_ROTRI = 5'b01011;

  function automatic opcode_t get_opcode(word_t instr);
    return instr[30:25];
  endfunction

  function automatic sub_opcode_t get_sub_opcode(word_t instr);
    return instr[4:0];
  endfunction

  function automatic reg_addr_t get_rt(word_t instr);
    return instr[24:20];
  endfunction

  function automatic reg_addr_t get_ra(word_t instr);
    return instr[19:15];
  endfunction

  // rb shares its bits with imm5
  function automatic reg_addr_t get_rb(word_t instr);
    return instr[14:10];
  endfunction

  function automatic logic [4:0] get_imm5(word_t instr);
    return instr[14:10];
  endfunction

  function automatic logic [14:0] get_imm15(word_t instr);
    return instr[14:0];
  endfunction

  function automatic logic [19:0] get_imm20(word_t instr);
    return instr[19:0];
  endfunction

endpackage

`default_nettype wire

// File: rtl/ctrl_pkg.sv
// internal control encodings shared between the controller and the datapath blocks
`default_nettype none

package ctrl_pkg;

  typedef enum logic [1:0] {
    ST_STOP = 2'b00,
    ST_FETCH = 2'b01,
    ST_EXECUTE = 2'b10,
    ST_WRITE = 2'b11
  } ctrl_state_t;

  typedef enum logic [1:0] {
    IMM5_ZE = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_kind_t;

  typedef enum logic {OPERAND_REG = 1'b0, OPERAND_IMM = 1'b1} operand_sel_t;

  // imm path is only taken by movi
  typedef enum logic {WB_ALU = 1'b0, WB_IMM = 1'b1} wb_sel_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_ROTR
  } alu_op_t;

endpackage

`default_nettype wire

// File: rtl/controller.sv
// sequencing FSM and instruction decode; drives the stage enables and datapath selects
`default_nettype none
`timescale 1ns/1ns

module controller import isa_pkg::*, ctrl_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         fetch_done,
  input  word_t        instruction,
  output logic         fetch_enable,
  output logic         execute_enable,
  output logic         writeback_enable,
  output imm_kind_t    imm_kind,
  output operand_sel_t operand_sel,
  output wb_sel_t      wb_sel,
  output alu_op_t      alu_op,
  output logic         write_request
);

  ctrl_state_t state;
  ctrl_state_t next_state;
  opcode_t     opcode;
  sub_opcode_t sub_opcode;
  logic        is_movi;
  logic        supported;

  assign opcode = get_opcode(instruction);
  assign sub_opcode = get_sub_opcode(instruction);
  assign is_movi = (opcode == OP_MOVI);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_STOP;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      ST_STOP: next_state = ST_FETCH;
      ST_FETCH: begin
        // wait states hold us here until ack
        if (fetch_done) begin
          next_state = is_movi ? ST_WRITE : ST_EXECUTE;
        end
      end
      ST_EXECUTE: next_state = ST_WRITE;
      default: next_state = ST_STOP;
    endcase
  end

  assign fetch_enable = (state == ST_FETCH);
  assign execute_enable = (state == ST_EXECUTE);
  assign writeback_enable = (state == ST_WRITE);

  always_comb begin
    imm_kind = IMM5_ZE;
    operand_sel = OPERAND_REG;
    wb_sel = WB_ALU;
    alu_op = ALU_ADD;
    supported = 1'b0;
    case (opcode)
      OP_ALU: begin
        supported = 1'b1;
        case (sub_opcode)
          SUB_ADD: alu_op = ALU_ADD;
          SUB_SUB: alu_op = ALU_SUB;
          SUB_AND: alu_op = ALU_AND;
          SUB_OR: alu_op = ALU_OR;
          SUB_XOR: alu_op = ALU_XOR;
          SUB_SLLI: begin
            alu_op = ALU_SLL;
            operand_sel = OPERAND_IMM;
          end
          SUB_SRLI: begin
            alu_op = ALU_SRL;
            operand_sel = OPERAND_IMM;
          end
          SUB_ROTRI: begin
            alu_op = ALU_ROTR;
            operand_sel = OPERAND_IMM;
          end
          default: supported = 1'b0;
        endcase
      end
      OP_ADDI: begin
        supported = 1'b1;
        imm_kind = IMM15_SE;
        operand_sel = OPERAND_IMM;
      end
      OP_ORI: begin
        supported = 1'b1;
        imm_kind = IMM15_ZE;
        operand_sel = OPERAND_IMM;
        alu_op = ALU_OR;
      end
      OP_XORI: begin
        supported = 1'b1;
        imm_kind = IMM15_ZE;
        operand_sel = OPERAND_IMM;
        alu_op = ALU_XOR;
      end
      OP_MOVI: begin
        supported = 1'b1;
        imm_kind = IMM20_SE;
        operand_sel = OPERAND_IMM;
        wb_sel = WB_IMM;
      end
      default: supported = 1'b0;
    endcase
  end

  // unknown opcodes still walk the sequence but never write
  assign write_request = writeback_enable & supported;

  a_one_enable: assert property (@(posedge clock) disable iff (reset)
    $onehot0({fetch_enable, execute_enable, writeback_enable}));

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
// program counter, Wishbone classic read master and instruction register of the core
`default_nettype none
`timescale 1ns/1ns

module fetch_unit import isa_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  fetch_enable,
  input  word_t wb_dat,
  input  logic  wb_ack,
  output logic  wb_cyc,
  output logic  wb_stb,
  output word_t wb_adr,
  output word_t instruction,
  output logic  fetch_done
);

  word_t pc;
  word_t instruction_reg;

  // one read per fetch state, strobes drop once the FSM moves on
  assign wb_cyc = fetch_enable;
  assign wb_stb = fetch_enable;
  assign wb_adr = pc;

  // ack is only meaningful under stb
  assign fetch_done = wb_stb & wb_ack;

  // decode sees the new word already in its ack cycle
  assign instruction = fetch_done ? wb_dat : instruction_reg;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (fetch_done) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      instruction_reg <= '0;
    end else if (fetch_done) begin
      instruction_reg <= wb_dat;
    end
  end

  a_stb_in_cyc: assert property (@(posedge clock) disable iff (reset)
    wb_stb |-> wb_cyc);

  // address held across wait states
  a_adr_stable: assert property (@(posedge clock) disable iff (reset)
    (wb_stb && !wb_ack) |=> $stable(wb_adr));

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// general purpose register file, two combinational read ports and one clocked write port
`default_nettype none
`timescale 1ns/1ns

module register_file import isa_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t read_address_a,
  input  reg_addr_t read_address_b,
  input  logic      write_enable,
  input  reg_addr_t write_address,
  input  word_t     write_data,
  output word_t     read_data_a,
  output word_t     read_data_b
);

  word_t regs [REG_COUNT];

  // r0 is an ordinary register here
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable) begin
      regs[write_address] <= write_data;
    end
  end

  assign read_data_a = regs[read_address_a];
  assign read_data_b = regs[read_address_b];

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
// immediate extension, operand select and ALU, with the registered writeback value
`default_nettype none
`timescale 1ns/1ns

module execute_unit import isa_pkg::*, ctrl_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         execute_enable,
  input  word_t        instruction,
  input  imm_kind_t    imm_kind,
  input  operand_sel_t operand_sel,
  input  wb_sel_t      wb_sel,
  input  alu_op_t      alu_op,
  input  word_t        operand_a,
  input  word_t        operand_b,
  output word_t        result
);

  word_t       imm_value;
  word_t       second_operand;
  word_t       alu_value;
  logic [4:0]  shift_amount;
  logic [63:0] rotate_pair;

  always_comb begin
    case (imm_kind)
      IMM5_ZE: imm_value = {27'd0, get_imm5(instruction)};
      IMM15_SE: imm_value = {{17{instruction[14]}}, get_imm15(instruction)};
      IMM15_ZE: imm_value = {17'd0, get_imm15(instruction)};
      default: imm_value = {{12{instruction[19]}}, get_imm20(instruction)};
    endcase
  end

  assign second_operand = (operand_sel == OPERAND_IMM) ? imm_value : operand_b;
  assign shift_amount = second_operand[4:0];

  // rotate right via a doubled word
  assign rotate_pair = {operand_a, operand_a} >> shift_amount;

  always_comb begin
    case (alu_op)
      ALU_ADD: alu_value = operand_a + second_operand;
      ALU_SUB: alu_value = operand_a - second_operand;
      ALU_AND: alu_value = operand_a & second_operand;
      ALU_OR: alu_value = operand_a | second_operand;
      ALU_XOR: alu_value = operand_a ^ second_operand;
      ALU_SLL: alu_value = operand_a << shift_amount;
      ALU_SRL: alu_value = operand_a >> shift_amount;
      default: alu_value = rotate_pair[31:0];
    endcase
  end

  // movi loads while the fetch bypass still shows it, so also in its ack cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (wb_sel == WB_IMM) begin
      result <= imm_value;
    end else if (execute_enable) begin
      result <= alu_value;
    end
  end

endmodule

`default_nettype wire

// File: rtl/nds_core.sv
// top level of the multicycle core; Wishbone instruction port in, register retires out
`default_nettype none
`timescale 1ns/1ns

module nds_core import isa_pkg::*, ctrl_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  word_t     wb_dat,
  input  logic      wb_ack,
  output logic      wb_cyc,
  output logic      wb_stb,
  output word_t     wb_adr,
  output logic      retire_valid,
  output reg_addr_t retire_address,
  output word_t     retire_data
);

  word_t        instruction;
  logic         fetch_enable;
  logic         execute_enable;
  logic         fetch_done;
  imm_kind_t    imm_kind;
  operand_sel_t operand_sel;
  wb_sel_t      wb_sel;
  alu_op_t      alu_op;
  logic         write_request;
  word_t        read_data_a;
  word_t        read_data_b;
  word_t        result;

  // retire mirrors the register file write port
  assign retire_valid = write_request;
  assign retire_address = get_rt(instruction);
  assign retire_data = result;

  controller controller_i (
    .clock            (clock),
    .reset            (reset),
    .fetch_done       (fetch_done),
    .instruction      (instruction),
    .fetch_enable     (fetch_enable),
    .execute_enable   (execute_enable),
    .writeback_enable (),
    .imm_kind         (imm_kind),
    .operand_sel      (operand_sel),
    .wb_sel           (wb_sel),
    .alu_op           (alu_op),
    .write_request    (write_request)
  );

  fetch_unit fetch_unit_i (
    .clock        (clock),
    .reset        (reset),
    .fetch_enable (fetch_enable),
    .wb_dat       (wb_dat),
    .wb_ack       (wb_ack),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .instruction  (instruction),
    .fetch_done   (fetch_done)
  );

  register_file register_file_i (
    .clock          (clock),
    .reset          (reset),
    .read_address_a (get_ra(instruction)),
    .read_address_b (get_rb(instruction)),
    .write_enable   (write_request),
    .write_address  (get_rt(instruction)),
    .write_data     (result),
    .read_data_a    (read_data_a),
    .read_data_b    (read_data_b)
  );

  execute_unit execute_unit_i (
    .clock          (clock),
    .reset          (reset),
    .execute_enable (execute_enable),
    .instruction    (instruction),
    .imm_kind       (imm_kind),
    .operand_sel    (operand_sel),
    .wb_sel         (wb_sel),
    .alu_op         (alu_op),
    .operand_a      (read_data_a),
    .operand_b      (read_data_b),
    .result         (result)
  );

endmodule

`default_nettype wire

// File: dv/nds_core_tb.sv
// directed testbench for nds_core; run from the project root through nds_core.f
`default_nettype none
`timescale 1ns/1ns

module nds_core_tb import isa_pkg::*; ();

  localparam int MEM_WORDS = 64;
  // program lengths of the six tests, in run order
  localparam int TOTAL_INSTRUCTIONS = 4 + 7 + 10 + 5 + 5 + 6;

  logic      clock = 1'b0;
  logic      reset;
  word_t     wb_dat;
  logic      wb_ack;
  logic      wb_cyc;
  logic      wb_stb;
  word_t     wb_adr;
  logic      retire_valid;
  reg_addr_t retire_address;
  word_t     retire_data;

  word_t       mem [MEM_WORDS];
  word_t       ref_regs [REG_COUNT];
  word_t       prog [$];
  reg_addr_t   exp_addr [$];
  word_t       exp_data [$];
  reg_addr_t   act_addr [$];
  word_t       act_data [$];
  word_t       fetch_addrs [$];
  word_t       end_address = '0;
  logic        end_fetched = 1'b0;
  logic        prev_stb = 1'b0;
  logic [31:0] lfsr = 32'hd018b44e;
  int          waits_left = -1;
  int          value_errors = 0;
  int          other_errors = 0;
  string       current_test = "startup";

  nds_core nds_core_i (
    .clock          (clock),
    .reset          (reset),
    .wb_dat         (wb_dat),
    .wb_ack         (wb_ack),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_adr         (wb_adr),
    .retire_valid   (retire_valid),
    .retire_address (retire_address),
    .retire_data    (retire_data)
  );

  always #10 clock = ~clock;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t reg_instr(sub_opcode_t sub, reg_addr_t rt, reg_addr_t ra,
                                      logic [4:0] rb);
    return {1'b0, OP_ALU, rt, ra, rb, 5'd0, sub};
  endfunction

  function automatic word_t imm_instr(opcode_t op, reg_addr_t rt, reg_addr_t ra,
                                      logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic word_t movi_instr(reg_addr_t rt, logic [19:0] imm);
    return {1'b0, OP_MOVI, rt, imm};
  endfunction

  // memory model with 0 to 3 wait states per read
  always @(negedge clock) begin
    if (reset || wb_ack) begin
      wb_ack <= 1'b0;
      waits_left = -1;
    end else if (wb_stb) begin
      if (waits_left < 0) begin
        waits_left = 0;
        repeat (2) begin
          lfsr = lfsr_next(lfsr);
          waits_left = waits_left * 2 + int'(lfsr[0]);
        end
      end
      if (waits_left == 0) begin
        wb_dat <= mem[wb_adr[7:2]];
        wb_ack <= 1'b1;
      end
      waits_left = waits_left - 1;
    end
  end

  always @(posedge clock) begin
    if (!reset) begin
      if (retire_valid) begin
        act_addr.push_back(retire_address);
        act_data.push_back(retire_data);
      end
      if (wb_cyc !== wb_stb) begin
        other_errors++;
        $display("%s: wb_cyc and wb_stb differ", current_test);
      end
      if (wb_stb && !prev_stb) begin
        fetch_addrs.push_back(wb_adr);
      end
      if (wb_stb && wb_adr == end_address) begin
        end_fetched = 1'b1;
      end
    end
    prev_stb = wb_stb;
  end

  initial begin
    repeat (TOTAL_INSTRUCTIONS * 8 + 100) @(posedge clock);
    $display("watchdog expired, %s did not finish", current_test);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      value_errors++;
      $display("ERR %s %s: expected %h, actual %h", current_test, what, expected, actual);
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t expected,
                           input reg_addr_t actual);
    if (expected !== actual) begin
      value_errors++;
      $display("ERR %s %s: expected r%0d, actual r%0d", current_test, what, expected, actual);
    end
  endtask

  // expected retire of one instruction, from the encoding rules
  task automatic predict(input word_t instr);
    word_t      a;
    word_t      b;
    word_t      value;
    logic [4:0] sh;
    logic       valid;
    a = ref_regs[instr[19:15]];
    b = ref_regs[instr[14:10]];
    sh = instr[14:10];
    valid = 1'b1;
    value = '0;
    case (instr[30:25])
      OP_MOVI: value = {{12{instr[19]}}, instr[19:0]};
      OP_ADDI: value = a + {{17{instr[14]}}, instr[14:0]};
      OP_ORI: value = a | {17'd0, instr[14:0]};
      OP_XORI: value = a ^ {17'd0, instr[14:0]};
      OP_ALU: begin
        case (instr[4:0])
          SUB_ADD: value = a + b;
          SUB_SUB: value = a - b;
          SUB_AND: value = a & b;
          SUB_OR: value = a | b;
          SUB_XOR: value = a ^ b;
          SUB_SLLI: value = a << sh;
          SUB_SRLI: value = a >> sh;
          SUB_ROTRI: begin
            value = a;
            repeat (sh) value = {value[0], value[31:1]};
          end
          default: valid = 1'b0;
        endcase
      end
      default: valid = 1'b0;
    endcase
    if (valid) begin
      ref_regs[instr[24:20]] = value;
      exp_addr.push_back(instr[24:20]);
      exp_data.push_back(value);
    end
  endtask

  task automatic apply_reset();
    @(negedge clock);
    reset <= 1'b1;
    act_addr.delete();
    act_data.delete();
    fetch_addrs.delete();
    end_fetched = 1'b0;
    repeat (10) begin
      @(negedge clock);
      if (wb_cyc || wb_stb) begin
        other_errors++;
        $display("%s: wishbone strobes active during reset", current_test);
      end
    end
    reset <= 1'b0;
  endtask

  // load, reset, run until the word after the program is fetched, compare
  task automatic run_program(input string name);
    current_test = name;
    exp_addr.delete();
    exp_data.delete();
    for (int r = 0; r < REG_COUNT; r++) begin
      ref_regs[r] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {7'h3f, 19'd0, 6'(i)};
    end
    foreach (prog[i]) begin
      mem[i] = prog[i];
      predict(prog[i]);
    end
    end_address = word_t'(prog.size() * 4);
    apply_reset();
    wait (end_fetched);
    if (act_addr.size() != exp_addr.size()) begin
      other_errors++;
      $display("%s: %0d retires seen, %0d expected", name, act_addr.size(), exp_addr.size());
    end
    foreach (exp_addr[i]) begin
      if (i < act_addr.size()) begin
        check_reg($sformatf("retire %0d address", i), exp_addr[i], act_addr[i]);
        check_word($sformatf("retire %0d data", i), exp_data[i], act_data[i]);
      end
    end
    prog.delete();
  endtask

  task automatic test_movi_sequence();
    prog.push_back(movi_instr(5'd5, 20'h7ffff));
    prog.push_back(movi_instr(5'd6, 20'h80000));
    prog.push_back(movi_instr(5'd1, 20'h12345));
    prog.push_back(movi_instr(5'd0, 20'hfffff));
    run_program("test_movi_sequence");
  endtask

  task automatic test_alu_register();
    prog.push_back(movi_instr(5'd1, 20'h0000c));
    prog.push_back(movi_instr(5'd2, 20'h12345));
    prog.push_back(reg_instr(SUB_ADD, 5'd3, 5'd1, 5'd2));
    // small minus large wraps around
    prog.push_back(reg_instr(SUB_SUB, 5'd4, 5'd1, 5'd2));
    prog.push_back(reg_instr(SUB_AND, 5'd5, 5'd1, 5'd2));
    prog.push_back(reg_instr(SUB_OR, 5'd6, 5'd1, 5'd2));
    prog.push_back(reg_instr(SUB_XOR, 5'd7, 5'd1, 5'd2));
    run_program("test_alu_register");
  endtask

  task automatic test_shift_rotate();
    logic [4:0] amounts [3] = '{5'd0, 5'd1, 5'd31};
    prog.push_back(movi_instr(5'd1, 20'h80001));
    foreach (amounts[i]) begin
      prog.push_back(reg_instr(SUB_SLLI, 5'(2 + i), 5'd1, amounts[i]));
      prog.push_back(reg_instr(SUB_SRLI, 5'(5 + i), 5'd1, amounts[i]));
      prog.push_back(reg_instr(SUB_ROTRI, 5'(8 + i), 5'd1, amounts[i]));
    end
    run_program("test_shift_rotate");
  endtask

  task automatic test_immediate_ops();
    prog.push_back(movi_instr(5'd1, 20'h0f0f0));
    prog.push_back(imm_instr(OP_ADDI, 5'd2, 5'd1, 15'h7fff));
    prog.push_back(imm_instr(OP_ADDI, 5'd3, 5'd1, 15'h4000));
    prog.push_back(imm_instr(OP_ORI, 5'd4, 5'd1, 15'h4001));
    prog.push_back(imm_instr(OP_XORI, 5'd5, 5'd1, 15'h7fff));
    run_program("test_immediate_ops");
  endtask

  task automatic test_unknown_opcode();
    prog.push_back(movi_instr(5'd1, 20'h00003));
    prog.push_back(imm_instr(6'b111111, 5'd2, 5'd1, 15'd7));
    prog.push_back(reg_instr(5'b11111, 5'd3, 5'd1, 5'd1));
    prog.push_back(reg_instr(SUB_ADD, 5'd4, 5'd1, 5'd1));
    prog.push_back(movi_instr(5'd5, 20'h00009));
    run_program("test_unknown_opcode");
  endtask

  task automatic test_fetch_addresses();
    for (int i = 0; i < 6; i++) begin
      prog.push_back(movi_instr(5'(10 + i), 20'(i * 3)));
    end
    run_program("test_fetch_addresses");
    if (fetch_addrs.size() == 0) begin
      other_errors++;
      $display("%s: no fetch was seen", current_test);
    end else begin
      // word addresses step by 4 from 0
      foreach (fetch_addrs[i]) begin
        check_word($sformatf("fetch %0d address", i), word_t'(i * 4), fetch_addrs[i]);
      end
    end
  endtask

  initial begin
    reset <= 1'b1;
    wb_ack <= 1'b0;
    wb_dat <= '0;
    test_movi_sequence();
    test_alu_register();
    test_shift_rotate();
    test_immediate_ops();
    test_unknown_opcode();
    test_fetch_addresses();
    $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: nds_core.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/controller.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/nds_core.sv
dv/nds_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module nds_core_tb -f nds_core.f \
  -o nds_core_sim \
  && ./obj_dir/nds_core_sim | tee /dev/stderr | grep -qx "TEST PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
